// ==== verilog.f ====
verilog/tag_sim_pkg.sv
verilog/tag_timing_if.sv
verilog/adc_mode_decode.sv
verilog/carrier_timebase.sv
verilog/ssp_tag_output.sv
verilog/hi_simulate_top.sv
test/tb_hi_simulate.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench and RTL with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module tb_hi_simulate \
    && ./obj_dir/Vtb_hi_simulate | tee /dev/stderr | grep -q "STATUS: PASS" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

exit 0

// ==== test/tb_hi_simulate.sv ====
/*
 * Testbench for the tag emulator front end
 * Applies a table of ADC, mode and host data rows and checks every
 * output each cycle against a cycle model of the front end
 */

`timescale 1ns/1ns
`default_nettype none

module tb_hi_simulate;

    logic       ssp_clk;
    logic       rst;
    logic [7:0] adc_d;
    logic [2:0] mod_type;
    logic       ssp_dout;
    logic       ssp_din;
    logic       ssp_frame;
    logic       pwr_oe1;
    logic       pwr_oe2;
    logic       pwr_oe4;
    logic       dbg;

    // One stimulus table entry per test row
    string      row_name[$];
    logic [7:0] row_adc[$];
    logic [2:0] row_mod[$];
    logic       row_dout[$];
    int         row_hold[$];

    // The model counts edges since reset release in n
    int         n;
    logic       m_hyst;
    logic       m_din;
    logic       m_frame;
    logic       m_mod;
    logic       m_listen;
    logic       m_bpsk;

    logic [31:0] rng;
    int          checks;
    int          errors;
    int          row_errors;
    int          cycle_count;
    int          cycle_limit;

    hi_simulate_top dut0 (
        .ssp_clk   (ssp_clk),
        .rst       (rst),
        .adc_d     (adc_d),
        .mod_type  (mod_type),
        .ssp_dout  (ssp_dout),
        .ssp_din   (ssp_din),
        .ssp_frame (ssp_frame),
        .pwr_oe1   (pwr_oe1),
        .pwr_oe2   (pwr_oe2),
        .pwr_oe4   (pwr_oe4),
        .dbg       (dbg)
    );

    // 40 ns carrier period
    always #20 ssp_clk = ~ssp_clk;

    // Watchdog that ends the run once the table length is exceeded
    always @(posedge ssp_clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count > cycle_limit)
        begin
            $display("Timeout after %0d cycles, the test table never finished", cycle_count);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        begin
            x = s;
            x = x ^ (x << 13);
            x = x ^ (x >> 17);
            x = x ^ (x << 5);
            return x;
        end
    endfunction

    task automatic add_row(input string name, input logic [7:0] adc, input logic [2:0] mod,
                           input logic dout, input int hold);
        begin
            row_name.push_back(name);
            row_adc.push_back(adc);
            row_mod.push_back(mod);
            row_dout.push_back(dout);
            row_hold.push_back(hold);
        end
    endtask

    task automatic build_table();
        logic [7:0] adc;
        begin
            // Top bits 111 set the comparator, 000 clear it and anything else holds it
            add_row("hyst set", 8'hE0, 3'd0, 1'b0, 40);
            add_row("hyst hold mixed", 8'h60, 3'd0, 1'b0, 40);
            add_row("hyst clear", 8'h1F, 3'd0, 1'b0, 40);
            add_row("hyst hold low", 8'h80, 3'd0, 1'b0, 40);
            add_row("hyst set again", 8'hFF, 3'd0, 1'b0, 20);
            add_row("hyst hold high", 8'hC3, 3'd0, 1'b0, 40);
            // Full frames so that both frame windows are seen
            add_row("listen frame", 8'hA0, 3'd0, 1'b1, 300);
            add_row("bpsk frame", 8'h40, 3'd1, 1'b1, 300);
            add_row("bpsk data low", 8'h20, 3'd1, 1'b0, 100);
            // Every other code must keep the enables low
            add_row("idle code 2", 8'h00, 3'd2, 1'b1, 60);
            add_row("idle code 3", 8'hE0, 3'd3, 1'b1, 40);
            add_row("idle code 5", 8'h55, 3'd5, 1'b0, 40);
            add_row("idle code 7", 8'hB7, 3'd7, 1'b1, 300);
            // Random BPSK rows with the ADC forced to a mixed sample
            for (int i = 0; i < 16; i++)
            begin
                rng = xorshift32(rng);
                adc = rng[15:8];
                if (adc[7:5] == 3'b111 || adc[7:5] == 3'b000)
                    adc[6] = ~adc[6];
                add_row("bpsk random", adc, 3'd1, rng[0], 8 + int'(rng[28:24]));
            end
        end
    endtask

    // Advances the model by one edge from the inputs held during the cycle
    task automatic step_model();
        logic nx_hyst;
        logic nx_din;
        logic nx_frame;
        logic nx_mod;
        int   pos;
        begin
            pos = n % 256;
            if (adc_d[7:5] == 3'b111)
                nx_hyst = 1'b1;
            else if (adc_d[7:5] == 3'b000)
                nx_hyst = 1'b0;
            else
                nx_hyst = m_hyst;
            // Host bit is taken at count 31 of each bit period
            nx_din = ((n % 32) == 31) ? m_hyst : m_din;
            // Listen frame spans cycles 0 to 31 and the modulating one 16 to 47
            nx_frame = m_listen ? (pos < 32) : (pos >= 16 && pos < 48);
            nx_mod = m_bpsk ? (ssp_dout ^ n[3]) : 1'b0;
            m_hyst = nx_hyst;
            m_din = nx_din;
            m_frame = nx_frame;
            m_mod = nx_mod;
            m_listen = (mod_type == 3'd0);
            m_bpsk = (mod_type == 3'd1);
            n = n + 1;
        end
    endtask

    task automatic check_sig(input string name, input logic actual, input logic expected);
        begin
            checks++;
            assert (actual === expected)
            else
            begin
                $display("Fail %s expected %h actual %h at cycle %0d", name, expected, actual, n);
                errors++;
                row_errors++;
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------

    initial
    begin
        ssp_clk = 1'b0;
        rst = 1'b1;
        adc_d = 8'h00;
        mod_type = 3'd0;
        ssp_dout = 1'b0;
        rng = 32'h6355;
        checks = 0;
        errors = 0;
        cycle_count = 0;
        cycle_limit = 0;

        build_table();
        cycle_limit = 16 + 64;
        foreach (row_hold[i])
            cycle_limit += row_hold[i];

        // Model matches the reset state of the DUT
        n = 0;
        m_hyst = 1'b0;
        m_din = 1'b0;
        m_frame = 1'b0;
        m_mod = 1'b0;
        m_listen = 1'b1;
        m_bpsk = 1'b0;

        repeat (16) @(posedge ssp_clk);
        #2 rst = 1'b0;

        for (int r = 0; r < row_hold.size(); r++)
        begin
            row_errors = 0;
            adc_d = row_adc[r];
            mod_type = row_mod[r];
            ssp_dout = row_dout[r];
            repeat (row_hold[r])
            begin
                @(posedge ssp_clk);
                step_model();
                #1;
                check_sig("dbg", dbg, m_hyst);
                check_sig("ssp_din", ssp_din, m_din);
                check_sig("ssp_frame", ssp_frame, m_frame);
                check_sig("pwr_oe1", pwr_oe1, m_mod);
                check_sig("pwr_oe2", pwr_oe2, m_mod);
                check_sig("pwr_oe4", pwr_oe4, m_mod);
                #1;
            end
            $display("test %0d %s: %0d cycles, %0d errors", r, row_name[r], row_hold[r],
                     row_errors);
        end

        $display("tests %0d, checks %0d, errors %0d", row_hold.size(), checks, errors);
        if (errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/hi_simulate_top.sv ====
/*
 * Tag emulator front end, top level
 * Joins the ADC and mode decode, the carrier time base and the
 * serial and modulation outputs
 */

`timescale 1ns/1ns
`default_nettype none

module hi_simulate_top (
    input  logic       ssp_clk,
    input  logic       rst,
    input  logic [7:0] adc_d,
    input  logic [2:0] mod_type,
    input  logic       ssp_dout,
    output logic       ssp_din,
    output logic       ssp_frame,
    output logic       pwr_oe1,
    output logic       pwr_oe2,
    output logic       pwr_oe4,
    output logic       dbg
);

    logic                   hyst_bit;
    tag_sim_pkg::tag_mode_e mode;

    // Time base shared by the divider and the output stage
    tag_timing_if tmg ();

    // Decode stage
    adc_mode_decode u_decode (
        .ssp_clk  (ssp_clk),
        .rst      (rst),
        .adc_d    (adc_d),
        .mod_type (mod_type),
        .hyst_bit (hyst_bit),
        .mode     (mode)
    );

    // Carrier division and framing
    carrier_timebase u_timebase (
        .ssp_clk (ssp_clk),
        .rst     (rst),
        .tmg     (tmg.timebase)
    );

    // Serial and modulation outputs
    ssp_tag_output u_output (
        .ssp_clk   (ssp_clk),
        .rst       (rst),
        .tmg       (tmg.consumer),
        .hyst_bit  (hyst_bit),
        .mode      (mode),
        .ssp_dout  (ssp_dout),
        .ssp_din   (ssp_din),
        .ssp_frame (ssp_frame),
        .pwr_oe1   (pwr_oe1),
        .pwr_oe2   (pwr_oe2),
        .pwr_oe4   (pwr_oe4)
    );

    // Comparator output straight to the debug pin
    assign dbg = hyst_bit;

endmodule

`default_nettype wire

// ==== verilog/ssp_tag_output.sv ====
/*
 * Serial port and load modulation outputs
 * Samples the receive bit once per bit period, picks the frame phase
 * for the current direction and forms the BPSK modulation enables
 */

`timescale 1ns/1ns
`default_nettype none

module ssp_tag_output (
    input  logic                   ssp_clk,
    input  logic                   rst,
    tag_timing_if.consumer         tmg,
    input  logic                   hyst_bit,
    input  tag_sim_pkg::tag_mode_e mode,
    input  logic                   ssp_dout,
    output logic                   ssp_din,
    output logic                   ssp_frame,
    output logic                   pwr_oe1,
    output logic                   pwr_oe2,
    output logic                   pwr_oe4
);

    logic frame_sel;
    logic mod_next;
    logic mod_en;

    // ------------------------------------------------------------------------
    // Receive to host
    // ------------------------------------------------------------------------

    // One sample per bit period, held until the next bit enable
    always_ff @(posedge ssp_clk)
    begin
        if (rst)
            ssp_din <= 1'b0;
        else if (tmg.bit_tick)
            ssp_din <= hyst_bit;
    end

    // Listening uses the receive phase, anything else the shifted one
    assign frame_sel = (mode == tag_sim_pkg::mode_listen) ? tmg.frame_tx : tmg.frame_rx;

    always_ff @(posedge ssp_clk)
    begin
        if (rst)
            ssp_frame <= 1'b0;
        else
            ssp_frame <= frame_sel;
    end

    // ------------------------------------------------------------------------
    // Load modulation
    // ------------------------------------------------------------------------

    // XOR with the subcarrier flips its phase per data bit, which is BPSK
    assign mod_next = (mode == tag_sim_pkg::mode_bpsk) ? (ssp_dout ^ tmg.subcarrier) : 1'b0;

    always_ff @(posedge ssp_clk)
    begin
        if (rst)
            mod_en <= 1'b0;
        else
            mod_en <= mod_next;
    end

    // All three tri-state drivers switch together for the deepest modulation
    assign pwr_oe1 = mod_en;
    assign pwr_oe2 = mod_en;
    assign pwr_oe4 = mod_en;

    a_no_mod_idle: assert property (@(posedge ssp_clk) disable iff (rst)
        (mode != tag_sim_pkg::mode_bpsk) |=> (!pwr_oe1 && !pwr_oe2 && !pwr_oe4));

endmodule

`default_nettype wire

// ==== verilog/carrier_timebase.sv ====
/*
 * Carrier time base
 * Divides the carrier into the serial bit enable, the BPSK subcarrier
 * and the frame levels for both directions
 */

`timescale 1ns/1ns
`default_nettype none

module carrier_timebase (
    input  logic          ssp_clk,
    input  logic          rst,
    tag_timing_if.timebase tmg
);

    logic [tag_sim_pkg::bit_div_w-1:0]   carrier_cnt;
    logic [tag_sim_pkg::frame_div_w-1:0] tx_frame_cnt;
    logic [tag_sim_pkg::frame_div_w-1:0] rx_frame_cnt;
    logic                                rx_step;

    // ------------------------------------------------------------------------
    // Carrier counter
    // ------------------------------------------------------------------------

    // Free running, 0 in the first cycle out of reset
    always_ff @(posedge ssp_clk)
    begin
        if (rst)
            carrier_cnt <= '0;
        else
            carrier_cnt <= carrier_cnt + 1'b1;
    end

    // Last cycle of the bit period
    assign tmg.bit_tick   = &carrier_cnt;
    assign tmg.subcarrier = carrier_cnt[tag_sim_pkg::subcarrier_bit];

    // Midpoint of the bit, where the modulating side steps
    assign rx_step = (carrier_cnt == tag_sim_pkg::rx_phase_count);

    // ------------------------------------------------------------------------
    // Frame counters
    // ------------------------------------------------------------------------

    // Listening side counts bits on the bit enable
    always_ff @(posedge ssp_clk)
    begin
        if (rst)
            tx_frame_cnt <= '0;
        else if (tmg.bit_tick)
            tx_frame_cnt <= tx_frame_cnt + 1'b1;
    end

    // Modulating side starts one step behind, so it reaches zero
    // half a bit after the listening side does
    always_ff @(posedge ssp_clk)
    begin
        if (rst)
            rx_frame_cnt <= '1;
        else if (rx_step)
            rx_frame_cnt <= rx_frame_cnt + 1'b1;
    end

    assign tmg.frame_tx = (tx_frame_cnt == '0);
    assign tmg.frame_rx = (rx_frame_cnt == '0);

    a_tick_single: assert property (@(posedge ssp_clk) disable iff (rst)
        tmg.bit_tick |=> !tmg.bit_tick);

    // The modulating frame opens exactly half a bit after the listening one
    a_frame_offset: assert property (@(posedge ssp_clk) disable iff (rst)
        $rose(tmg.frame_tx) |-> ##(tag_sim_pkg::rx_phase_count + 1) $rose(tmg.frame_rx));

endmodule

`default_nettype wire

// ==== verilog/adc_mode_decode.sv ====
/*
 * ADC hysteresis comparator and mode decode
 * Turns the top ADC bits into one receive bit and registers the
 * modulation mode taken from mod_type
 */

`timescale 1ns/1ns
`default_nettype none

module adc_mode_decode (
    input  logic                   ssp_clk,
    input  logic                   rst,
    input  logic [7:0]             adc_d,
    input  logic [2:0]             mod_type,
    output logic                   hyst_bit,
    output tag_sim_pkg::tag_mode_e mode
);

    // Only the upper bits of the sample matter to the comparator
    logic [tag_sim_pkg::adc_hyst_msb-tag_sim_pkg::adc_hyst_lsb:0] adc_sel;
    logic                                                         adc_high;
    logic                                                         adc_low;

    assign adc_sel  = adc_d[tag_sim_pkg::adc_hyst_msb:tag_sim_pkg::adc_hyst_lsb];
    assign adc_high = &adc_sel;
    assign adc_low  = ~|adc_sel;

    // ------------------------------------------------------------------------
    // Hysteresis
    // ------------------------------------------------------------------------

    // The peak detector output is high-pass filtered, so a level is only
    // seen as an edge. Setting on all ones and clearing on all zeros
    // restores the level, and a mixed sample keeps the last decision
    always_ff @(posedge ssp_clk)
    begin
        if (rst)
            hyst_bit <= 1'b0;
        else if (adc_high)
            hyst_bit <= 1'b1;
        else if (adc_low)
            hyst_bit <= 1'b0;
    end

    // Mode decode, one cycle of latency
    always_ff @(posedge ssp_clk)
    begin
        if (rst)
            mode <= tag_sim_pkg::mode_listen;
        else
        begin
            case (mod_type)
                3'd0:    mode <= tag_sim_pkg::mode_listen;
                3'd1:    mode <= tag_sim_pkg::mode_bpsk;
                default: mode <= tag_sim_pkg::mode_idle;
            endcase
        end
    end

    // A mixed sample must leave the comparator where it was
    a_hyst_hold: assert property (@(posedge ssp_clk) disable iff (rst)
        (!adc_high && !adc_low) |=> $stable(hyst_bit));

endmodule

`default_nettype wire

// ==== verilog/tag_timing_if.sv ====
/*
 * Tag timing interface
 * Carries the bit enable, subcarrier and both frame levels from the
 * carrier divider to the serial output stage
 */

`timescale 1ns/1ns
`default_nettype none

interface tag_timing_if;

    // One-cycle pulse at carrier count 31, marks the serial bit period
    logic bit_tick;

    // Carrier divided by 16, used for BPSK
    logic subcarrier;

    // Frame level for the listening direction
    logic frame_tx;

    // Frame level for the modulating direction, half a bit later
    logic frame_rx;

    // The divider drives every signal
    modport timebase (output bit_tick, output subcarrier, output frame_tx, output frame_rx);

    // The output stage only reads them
    modport consumer (input bit_tick, input subcarrier, input frame_tx, input frame_rx);

endinterface

`default_nettype wire

// ==== verilog/tag_sim_pkg.sv ====
/*
 * Tag emulator shared definitions
 * Mode encoding, divider widths and the ADC bits seen by the
 * hysteresis comparator
 */

`default_nettype none

package tag_sim_pkg;

    // ------------------------------------------------------------------------
    // Modulation mode
    // ------------------------------------------------------------------------

    // Listen sends samples to the host, BPSK drives the load modulation
    // and every other mod_type code parks the front end in idle
    typedef enum logic [1:0] {
        mode_listen = 2'd0,
        mode_bpsk   = 2'd1,
        mode_idle   = 2'd2
    } tag_mode_e;

    // ------------------------------------------------------------------------
    // Time base
    // ------------------------------------------------------------------------

    // Carrier counter width, one serial bit is 32 carrier cycles
    localparam int bit_div_w = 5;

    // Bit counter width, eight bits to a frame
    localparam int frame_div_w = 3;

    // Counter bit 3 toggles every 8 cycles, so the subcarrier is fc/16
    localparam int subcarrier_bit = 3;

    // The modulating frame counter steps half a bit after the listening one
    localparam logic [bit_div_w-1:0] rx_phase_count = 15;

    // Top three ADC bits feed the comparator
    localparam int adc_hyst_msb = 7;
    localparam int adc_hyst_lsb = 5;

endpackage

`default_nettype wire
